/* rtl/exe_pkg.sv */
// ----------------------------------------
// execute stage package
// widths and encodings shared by the ALU,
// hazard block and execute/memory register
// ----------------------------------------
`default_nettype none

package exe_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int XLEN       = 32;
	localparam int REG_W      = 5;
	localparam int ALU_OP_W   = 4;
	localparam int BR_W       = 3;
	localparam int MUX_W      = 5;
	localparam int FWD_W      = 2;
	localparam int WB_SX_W    = 3;
	localparam int L1D_SIZE_W = 3;

	// ----------------------------------------
	// alu operations
	// ----------------------------------------
	localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
	localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

	// ----------------------------------------
	// branch conditions
	// ----------------------------------------
	localparam logic [BR_W-1:0] BR_NONE = 3'd0;
	localparam logic [BR_W-1:0] BR_EQ   = 3'd1;
	localparam logic [BR_W-1:0] BR_NE   = 3'd2;
	localparam logic [BR_W-1:0] BR_LT   = 3'd3;
	localparam logic [BR_W-1:0] BR_GE   = 3'd4;
	localparam logic [BR_W-1:0] BR_LTU  = 3'd5;
	localparam logic [BR_W-1:0] BR_GEU  = 3'd6;
	localparam logic [BR_W-1:0] BR_JUMP = 3'd7;

	// bit positions in the operand-select bus
	localparam int SEL_A_PC     = 0;
	localparam int SEL_B_IMM    = 1;
	localparam int SEL_ADDR_PC  = 2;
	localparam int SEL_ADDR_RS1 = 3;
	localparam int SEL_RES_MEM  = 4;

	// bypass selects
	localparam logic [FWD_W-1:0] FWD_RF  = 2'd0;
	localparam logic [FWD_W-1:0] FWD_MEM = 2'd1;
	localparam logic [FWD_W-1:0] FWD_WB  = 2'd2;

	// load extension code of a bubble
	localparam logic [WB_SX_W-1:0] WB_SX_NONE = 3'd7;

endpackage

`default_nettype wire

/* rtl/exe_alu.sv */
// ----------------------------------------
// execute ALU
// arithmetic, logic and shift operations
// plus branch condition evaluation
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
	input  logic [exe_pkg::XLEN-1:0]     a,
	input  logic [exe_pkg::XLEN-1:0]     b,
	input  logic [exe_pkg::ALU_OP_W-1:0] alu_op,
	input  logic [exe_pkg::XLEN-1:0]     cmp_a,
	input  logic [exe_pkg::XLEN-1:0]     cmp_b,
	input  logic [exe_pkg::BR_W-1:0]     br_cnd,
	output logic [exe_pkg::XLEN-1:0]     result,
	output logic                         taken
);
	import exe_pkg::*;

	logic [4:0] shamt;
	logic       cmp_eq;
	logic       cmp_lt;
	logic       cmp_ltu;

	// shift amount is the low five bits of b
	assign shamt = b[4:0];

	// ----------------------------------------
	// operation select
	// ----------------------------------------
	always_comb begin
		case (alu_op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_SLL:    result = a << shamt;
			ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU:   result = {{(XLEN-1){1'b0}}, a < b};
			ALU_XOR:    result = a ^ b;
			ALU_SRL:    result = a >> shamt;
			ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
			ALU_OR:     result = a | b;
			ALU_AND:    result = a & b;
			ALU_PASS_B: result = b;
			default:    result = '0;
		endcase
	end

	// ----------------------------------------
	// branch compare
	// ----------------------------------------
	// compares the forwarded registers, not the alu inputs
	assign cmp_eq  = (cmp_a == cmp_b);
	assign cmp_lt  = ($signed(cmp_a) < $signed(cmp_b));
	assign cmp_ltu = (cmp_a < cmp_b);

	always_comb begin
		case (br_cnd)
			BR_NONE: taken = 1'b0;
			BR_EQ:   taken = cmp_eq;
			BR_NE:   taken = !cmp_eq;
			BR_LT:   taken = cmp_lt;
			BR_GE:   taken = !cmp_lt;
			BR_LTU:  taken = cmp_ltu;
			BR_GEU:  taken = !cmp_ltu;
			BR_JUMP: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/exe_hazard.sv */
// ----------------------------------------
// execute hazard block
// bypass selects for both sources and
// load-use detection
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exe_hazard (
	input  logic [exe_pkg::REG_W-1:0] rs1,
	input  logic [exe_pkg::REG_W-1:0] rs2,
	input  logic [exe_pkg::REG_W-1:0] mem_rd,
	input  logic                      mem_we,
	input  logic                      mem_load,
	input  logic [exe_pkg::REG_W-1:0] wb_rd,
	input  logic                      wb_we,
	output logic [exe_pkg::FWD_W-1:0] fwd_a,
	output logic [exe_pkg::FWD_W-1:0] fwd_b,
	output logic                      load_use
);
	import exe_pkg::*;

	logic mem_hit_a;
	logic mem_hit_b;

	// memory stage has priority over writeback and x0 is never forwarded
	function automatic logic [FWD_W-1:0] pick_fwd(input logic [REG_W-1:0] rs);
		logic [FWD_W-1:0] sel;
		sel = FWD_RF;
		if (rs != '0) begin
			if (mem_we && (mem_rd == rs)) begin
				sel = FWD_MEM;
			end else if (wb_we && (wb_rd == rs)) begin
				sel = FWD_WB;
			end
		end
		return sel;
	endfunction

	always_comb begin
		fwd_a = pick_fwd(rs1);
		fwd_b = pick_fwd(rs2);
	end

	// ----------------------------------------
	// load-use
	// ----------------------------------------
	// a nonzero mem_rd match implies a nonzero source
	assign mem_hit_a = (mem_rd != '0) && (mem_rd == rs1);
	assign mem_hit_b = (mem_rd != '0) && (mem_rd == rs2);

	// loaded data is not ready until after the memory stage
	assign load_use = mem_load && mem_we && (mem_hit_a || mem_hit_b);

endmodule

`default_nettype wire

/* rtl/exe_stage.sv */
// ----------------------------------------
// execute stage datapath
// forwarding, operand select, ALU, address
// adder and the execute/memory register
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           enb,
	input  logic                           kill,
	// decode controls
	input  logic                           we_reg_file,
	input  logic [exe_pkg::WB_SX_W-1:0]    wb_sx_op,
	input  logic [exe_pkg::MUX_W-1:0]      mux_bus,
	input  logic [exe_pkg::ALU_OP_W-1:0]   alu_op,
	input  logic [exe_pkg::BR_W-1:0]       br_cnd,
	input  logic                           l1d_val,
	input  logic                           l1d_wr,
	input  logic [exe_pkg::L1D_SIZE_W-1:0] l1d_size,
	// decode data
	input  logic [exe_pkg::XLEN-1:0]       src1,
	input  logic [exe_pkg::XLEN-1:0]       src2,
	input  logic [exe_pkg::XLEN-1:0]       pc,
	input  logic [exe_pkg::XLEN-1:0]       pc_4,
	input  logic [exe_pkg::XLEN-1:0]       sx_imm,
	input  logic [exe_pkg::REG_W-1:0]      rs1,
	input  logic [exe_pkg::REG_W-1:0]      rs2,
	input  logic [exe_pkg::REG_W-1:0]      rd,
	// bypass
	input  logic [exe_pkg::XLEN-1:0]       wb_result,
	input  logic [exe_pkg::FWD_W-1:0]      fwd_a,
	input  logic [exe_pkg::FWD_W-1:0]      fwd_b,
	// execute/memory register
	output logic                           we_reg_file_q,
	output logic [exe_pkg::WB_SX_W-1:0]    wb_sx_op_q,
	output logic                           l1d_val_q,
	output logic                           l1d_wr_q,
	output logic [exe_pkg::L1D_SIZE_W-1:0] l1d_size_q,
	output logic                           result_sel_mem_q,
	output logic [exe_pkg::XLEN-1:0]       alu_result_q,
	output logic [exe_pkg::XLEN-1:0]       w_data_q,
	output logic [exe_pkg::XLEN-1:0]       addr_q,
	output logic [exe_pkg::XLEN-1:0]       pc_4_q,
	output logic [exe_pkg::REG_W-1:0]      rd_q,
	// to hazard block and fetch
	output logic [exe_pkg::REG_W-1:0]      rs1_h,
	output logic [exe_pkg::REG_W-1:0]      rs2_h,
	output logic                           branch_taken,
	output logic [exe_pkg::XLEN-1:0]       branch_target
);
	import exe_pkg::*;

	logic [XLEN-1:0] op1_fwd;
	logic [XLEN-1:0] op2_fwd;
	logic [XLEN-1:0] alu_a;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] addr_base;

	// pick decode operand, memory-stage result or writeback result
	function automatic logic [XLEN-1:0] fwd_mux(
		input logic [FWD_W-1:0] sel,
		input logic [XLEN-1:0]  rf_val
	);
		logic [XLEN-1:0] val;
		case (sel)
			FWD_MEM: val = alu_result_q;
			FWD_WB:  val = wb_result;
			default: val = rf_val;
		endcase
		return val;
	endfunction

	// ----------------------------------------
	// forwarding and operand select
	// ----------------------------------------
	always_comb begin
		op1_fwd = fwd_mux(fwd_a, src1);
		op2_fwd = fwd_mux(fwd_b, src2);
	end

	assign alu_a = mux_bus[SEL_A_PC]  ? pc     : op1_fwd;
	assign alu_b = mux_bus[SEL_B_IMM] ? sx_imm : op2_fwd;

	exe_alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.alu_op (alu_op),
		.cmp_a  (op1_fwd),
		.cmp_b  (op2_fwd),
		.br_cnd (br_cnd),
		.result (alu_result),
		.taken  (branch_taken)
	);

	// address base is pc, rs1 or pc_4 in that order
	always_comb begin
		if (mux_bus[SEL_ADDR_PC]) begin
			addr_base = pc;
		end else if (mux_bus[SEL_ADDR_RS1]) begin
			addr_base = op1_fwd;
		end else begin
			addr_base = pc_4;
		end
	end

	assign branch_target = sx_imm + addr_base;

	// sources go straight to the hazard block
	assign rs1_h = rs1;
	assign rs2_h = rs2;

	// ----------------------------------------
	// execute/memory register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst || kill) begin
			// bubble
			we_reg_file_q    <= 1'b0;
			wb_sx_op_q       <= WB_SX_NONE;
			l1d_val_q        <= 1'b0;
			l1d_wr_q         <= 1'b0;
			l1d_size_q       <= '0;
			result_sel_mem_q <= 1'b0;
			alu_result_q     <= '0;
			w_data_q         <= '0;
			addr_q           <= '0;
			pc_4_q           <= '0;
			rd_q             <= '0;
		end else if (enb) begin
			we_reg_file_q    <= we_reg_file;
			wb_sx_op_q       <= wb_sx_op;
			l1d_val_q        <= l1d_val;
			l1d_wr_q         <= l1d_wr;
			l1d_size_q       <= l1d_size;
			result_sel_mem_q <= mux_bus[SEL_RES_MEM];
			alu_result_q     <= alu_result;
			// store data is the forwarded rs2
			w_data_q         <= op2_fwd;
			addr_q           <= branch_target;
			pc_4_q           <= pc_4;
			rd_q             <= rd;
		end
	end

endmodule

`default_nettype wire

/* rtl/exe_top.sv */
// ----------------------------------------
// execute subsystem top
// stage datapath with its hazard block
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exe_top (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           enb,
	input  logic                           kill,
	// decode
	input  logic                           we_reg_file,
	input  logic [exe_pkg::WB_SX_W-1:0]    wb_sx_op,
	input  logic [exe_pkg::MUX_W-1:0]      mux_bus,
	input  logic [exe_pkg::ALU_OP_W-1:0]   alu_op,
	input  logic [exe_pkg::BR_W-1:0]       br_cnd,
	input  logic                           l1d_val,
	input  logic                           l1d_wr,
	input  logic [exe_pkg::L1D_SIZE_W-1:0] l1d_size,
	input  logic [exe_pkg::XLEN-1:0]       src1,
	input  logic [exe_pkg::XLEN-1:0]       src2,
	input  logic [exe_pkg::XLEN-1:0]       pc,
	input  logic [exe_pkg::XLEN-1:0]       pc_4,
	input  logic [exe_pkg::XLEN-1:0]       sx_imm,
	input  logic [exe_pkg::REG_W-1:0]      rs1,
	input  logic [exe_pkg::REG_W-1:0]      rs2,
	input  logic [exe_pkg::REG_W-1:0]      rd,
	// writeback
	input  logic [exe_pkg::XLEN-1:0]       wb_result,
	input  logic [exe_pkg::REG_W-1:0]      wb_rd,
	input  logic                           wb_we,
	// to memory stage
	output logic                           we_reg_file_q,
	output logic [exe_pkg::WB_SX_W-1:0]    wb_sx_op_q,
	output logic                           l1d_val_q,
	output logic                           l1d_wr_q,
	output logic [exe_pkg::L1D_SIZE_W-1:0] l1d_size_q,
	output logic                           result_sel_mem_q,
	output logic [exe_pkg::XLEN-1:0]       alu_result_q,
	output logic [exe_pkg::XLEN-1:0]       w_data_q,
	output logic [exe_pkg::XLEN-1:0]       addr_q,
	output logic [exe_pkg::XLEN-1:0]       pc_4_q,
	output logic [exe_pkg::REG_W-1:0]      rd_q,
	// to fetch and pipeline control
	output logic                           branch_taken,
	output logic [exe_pkg::XLEN-1:0]       branch_target,
	output logic                           load_use
);
	import exe_pkg::*;

	logic [REG_W-1:0] rs1_h;
	logic [REG_W-1:0] rs2_h;
	logic [FWD_W-1:0] fwd_a;
	logic [FWD_W-1:0] fwd_b;
	logic             mem_load;

	// memory-stage instruction is a load
	assign mem_load = l1d_val_q && !l1d_wr_q;

	exe_stage u_stage (
		.clk              (clk),
		.rst              (rst),
		.enb              (enb),
		.kill             (kill),
		.we_reg_file      (we_reg_file),
		.wb_sx_op         (wb_sx_op),
		.mux_bus          (mux_bus),
		.alu_op           (alu_op),
		.br_cnd           (br_cnd),
		.l1d_val          (l1d_val),
		.l1d_wr           (l1d_wr),
		.l1d_size         (l1d_size),
		.src1             (src1),
		.src2             (src2),
		.pc               (pc),
		.pc_4             (pc_4),
		.sx_imm           (sx_imm),
		.rs1              (rs1),
		.rs2              (rs2),
		.rd               (rd),
		.wb_result        (wb_result),
		.fwd_a            (fwd_a),
		.fwd_b            (fwd_b),
		.we_reg_file_q    (we_reg_file_q),
		.wb_sx_op_q       (wb_sx_op_q),
		.l1d_val_q        (l1d_val_q),
		.l1d_wr_q         (l1d_wr_q),
		.l1d_size_q       (l1d_size_q),
		.result_sel_mem_q (result_sel_mem_q),
		.alu_result_q     (alu_result_q),
		.w_data_q         (w_data_q),
		.addr_q           (addr_q),
		.pc_4_q           (pc_4_q),
		.rd_q             (rd_q),
		.rs1_h            (rs1_h),
		.rs2_h            (rs2_h),
		.branch_taken     (branch_taken),
		.branch_target    (branch_target)
	);

	exe_hazard u_hazard (
		.rs1      (rs1_h),
		.rs2      (rs2_h),
		.mem_rd   (rd_q),
		.mem_we   (we_reg_file_q),
		.mem_load (mem_load),
		.wb_rd    (wb_rd),
		.wb_we    (wb_we),
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b),
		.load_use (load_use)
	);

endmodule

`default_nettype wire

/* sim/exe_assert.sv */
// ----------------------------------------
// execute stage assertions
// bubble after reset or kill, hold on stall
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exe_assert (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           enb,
	input  logic                           kill,
	input  logic                           we_reg_file_q,
	input  logic [exe_pkg::WB_SX_W-1:0]    wb_sx_op_q,
	input  logic                           l1d_val_q,
	input  logic                           l1d_wr_q,
	input  logic [exe_pkg::L1D_SIZE_W-1:0] l1d_size_q,
	input  logic                           result_sel_mem_q,
	input  logic [exe_pkg::XLEN-1:0]       alu_result_q,
	input  logic [exe_pkg::XLEN-1:0]       w_data_q,
	input  logic [exe_pkg::XLEN-1:0]       addr_q,
	input  logic [exe_pkg::XLEN-1:0]       pc_4_q,
	input  logic [exe_pkg::REG_W-1:0]      rd_q
);
	import exe_pkg::*;

	// bubble in the cycle after rst or kill
	a_bubble: assert property (@(posedge clk) (rst || kill) |=>
		(!we_reg_file_q && !l1d_val_q && !l1d_wr_q && !result_sel_mem_q
		&& (wb_sx_op_q == WB_SX_NONE)))
		else $error("execute/memory controls not cleared after rst or kill");

	// stall without kill holds every field
	a_hold: assert property (@(posedge clk) (!rst && !kill && !enb) |=>
		($stable(we_reg_file_q) && $stable(wb_sx_op_q) && $stable(l1d_val_q)
		&& $stable(l1d_wr_q) && $stable(l1d_size_q) && $stable(result_sel_mem_q)
		&& $stable(alu_result_q) && $stable(w_data_q) && $stable(addr_q)
		&& $stable(pc_4_q) && $stable(rd_q)))
		else $error("execute/memory register changed while stalled");

endmodule

bind exe_stage exe_assert u_assert (
	.clk              (clk),
	.rst              (rst),
	.enb              (enb),
	.kill             (kill),
	.we_reg_file_q    (we_reg_file_q),
	.wb_sx_op_q       (wb_sx_op_q),
	.l1d_val_q        (l1d_val_q),
	.l1d_wr_q         (l1d_wr_q),
	.l1d_size_q       (l1d_size_q),
	.result_sel_mem_q (result_sel_mem_q),
	.alu_result_q     (alu_result_q),
	.w_data_q         (w_data_q),
	.addr_q           (addr_q),
	.pc_4_q           (pc_4_q),
	.rd_q             (rd_q)
);

`default_nettype wire

/* sim/exe_checker.sv */
// ----------------------------------------
// execute stage checker
// reference model of the stage, compares
// combinational and registered outputs
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exe_checker (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           enb,
	input  logic                           kill,
	input  logic                           we_reg_file,
	input  logic [exe_pkg::WB_SX_W-1:0]    wb_sx_op,
	input  logic [exe_pkg::MUX_W-1:0]      mux_bus,
	input  logic [exe_pkg::ALU_OP_W-1:0]   alu_op,
	input  logic [exe_pkg::BR_W-1:0]       br_cnd,
	input  logic                           l1d_val,
	input  logic                           l1d_wr,
	input  logic [exe_pkg::L1D_SIZE_W-1:0] l1d_size,
	input  logic [exe_pkg::XLEN-1:0]       src1,
	input  logic [exe_pkg::XLEN-1:0]       src2,
	input  logic [exe_pkg::XLEN-1:0]       pc,
	input  logic [exe_pkg::XLEN-1:0]       pc_4,
	input  logic [exe_pkg::XLEN-1:0]       sx_imm,
	input  logic [exe_pkg::REG_W-1:0]      rs1,
	input  logic [exe_pkg::REG_W-1:0]      rs2,
	input  logic [exe_pkg::REG_W-1:0]      rd,
	input  logic [exe_pkg::XLEN-1:0]       wb_result,
	input  logic [exe_pkg::REG_W-1:0]      wb_rd,
	input  logic                           wb_we,
	input  logic                           we_reg_file_q,
	input  logic [exe_pkg::WB_SX_W-1:0]    wb_sx_op_q,
	input  logic                           l1d_val_q,
	input  logic                           l1d_wr_q,
	input  logic [exe_pkg::L1D_SIZE_W-1:0] l1d_size_q,
	input  logic                           result_sel_mem_q,
	input  logic [exe_pkg::XLEN-1:0]       alu_result_q,
	input  logic [exe_pkg::XLEN-1:0]       w_data_q,
	input  logic [exe_pkg::XLEN-1:0]       addr_q,
	input  logic [exe_pkg::XLEN-1:0]       pc_4_q,
	input  logic [exe_pkg::REG_W-1:0]      rd_q,
	input  logic                           branch_taken,
	input  logic [exe_pkg::XLEN-1:0]       branch_target,
	input  logic                           load_use,
	output int                             err_cnt,
	output int                             chk_cnt
);
	import exe_pkg::*;

	// model of the execute/memory register
	logic                  m_we;
	logic [WB_SX_W-1:0]    m_sx;
	logic                  m_val;
	logic                  m_wr;
	logic [L1D_SIZE_W-1:0] m_size;
	logic                  m_sel_mem;
	logic [XLEN-1:0]       m_alu;
	logic [XLEN-1:0]       m_wdata;
	logic [XLEN-1:0]       m_addr;
	logic [XLEN-1:0]       m_pc_4;
	logic [REG_W-1:0]      m_rd;
	logic                  model_ok = 1'b0;
	int                    errs = 0;
	int                    checks = 0;

	assign err_cnt = errs;
	assign chk_cnt = checks;

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errs++;
			$display("FAIL %s at %0t: expected 0x%h, got 0x%h", name, $time, exp, act);
		end
	endtask

	// ----------------------------------------
	// reference rules
	// ----------------------------------------
	// memory stage first, then writeback, x0 stays the decode value
	function automatic logic [XLEN-1:0] bypass_value(input logic [REG_W-1:0] rs,
		input logic [XLEN-1:0] rf_val);
		logic [XLEN-1:0] v;
		v = rf_val;
		if (rs != 5'd0 && m_we && m_rd == rs) v = m_alu;
		else if (rs != 5'd0 && wb_we && wb_rd == rs) v = wb_result;
		return v;
	endfunction

	function automatic logic [XLEN-1:0] alu_ref(input logic [ALU_OP_W-1:0] op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [63:0]     ext;
		logic [XLEN-1:0] res;
		// sign-filled upper half gives the arithmetic shift
		ext = {{32{a[31]}}, a} >> b[4:0];
		case (op)
			ALU_ADD:    res = a + b;
			ALU_SUB:    res = a + ~b + 32'd1;
			ALU_SLL:    res = a << b[4:0];
			ALU_SLT:    res = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
			ALU_SLTU:   res = {31'b0, a < b};
			ALU_XOR:    res = a ^ b;
			ALU_SRL:    res = a >> b[4:0];
			ALU_SRA:    res = ext[31:0];
			ALU_OR:     res = a | b;
			ALU_AND:    res = a & b;
			ALU_PASS_B: res = b;
			default:    res = 32'd0;
		endcase
		return res;
	endfunction

	function automatic logic branch_ref(input logic [BR_W-1:0] cnd,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic lt_s;
		logic res;
		lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
		case (cnd)
			BR_EQ:   res = (a == b);
			BR_NE:   res = (a != b);
			BR_LT:   res = lt_s;
			BR_GE:   res = !lt_s;
			BR_LTU:  res = (a < b);
			BR_GEU:  res = (a >= b);
			BR_JUMP: res = 1'b1;
			default: res = 1'b0;
		endcase
		return res;
	endfunction

	// ----------------------------------------
	// compare and advance the model
	// ----------------------------------------
	always @(posedge clk) begin : check_proc
		logic [XLEN-1:0] op1;
		logic [XLEN-1:0] op2;
		logic [XLEN-1:0] base;
		logic [XLEN-1:0] target;
		logic            lu;
		op1 = bypass_value(rs1, src1);
		op2 = bypass_value(rs2, src2);
		if (mux_bus[SEL_ADDR_PC]) base = pc;
		else if (mux_bus[SEL_ADDR_RS1]) base = op1;
		else base = pc_4;
		target = base + sx_imm;
		lu = m_val && !m_wr && m_we && (m_rd != 5'd0) && (m_rd == rs1 || m_rd == rs2);
		if (model_ok) begin
			compare_value("we_reg_file_q", 32'(m_we), 32'(we_reg_file_q));
			compare_value("wb_sx_op_q", 32'(m_sx), 32'(wb_sx_op_q));
			compare_value("l1d_val_q", 32'(m_val), 32'(l1d_val_q));
			compare_value("l1d_wr_q", 32'(m_wr), 32'(l1d_wr_q));
			compare_value("l1d_size_q", 32'(m_size), 32'(l1d_size_q));
			compare_value("result_sel_mem_q", 32'(m_sel_mem), 32'(result_sel_mem_q));
			compare_value("alu_result_q", m_alu, alu_result_q);
			compare_value("w_data_q", m_wdata, w_data_q);
			compare_value("addr_q", m_addr, addr_q);
			compare_value("pc_4_q", m_pc_4, pc_4_q);
			compare_value("rd_q", 32'(m_rd), 32'(rd_q));
			compare_value("branch_taken", 32'(branch_ref(br_cnd, op1, op2)),
				32'(branch_taken));
			compare_value("branch_target", target, branch_target);
			compare_value("load_use", 32'(lu), 32'(load_use));
		end
		if (rst || kill) begin
			m_we      = 1'b0;
			m_sx      = WB_SX_NONE;
			m_val     = 1'b0;
			m_wr      = 1'b0;
			m_size    = '0;
			m_sel_mem = 1'b0;
			m_alu     = '0;
			m_wdata   = '0;
			m_addr    = '0;
			m_pc_4    = '0;
			m_rd      = '0;
			model_ok  = 1'b1;
		end else if (enb && model_ok) begin
			m_we      = we_reg_file;
			m_sx      = wb_sx_op;
			m_val     = l1d_val;
			m_wr      = l1d_wr;
			m_size    = l1d_size;
			m_sel_mem = mux_bus[SEL_RES_MEM];
			m_alu     = alu_ref(alu_op, mux_bus[SEL_A_PC] ? pc : op1,
				mux_bus[SEL_B_IMM] ? sx_imm : op2);
			m_wdata   = op2;
			m_addr    = target;
			m_pc_4    = pc_4;
			m_rd      = rd;
		end
	end

endmodule

`default_nettype wire

/* sim/exe_tb.sv */
// ----------------------------------------
// execute stage testbench
// random instruction stream per test,
// watchdog and DUT with its checker
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module exe_tb;
	import exe_pkg::*;

	localparam int          CLK_PERIOD = 8;
	localparam int          RST_CYCLES = 16;
	localparam int          N_RAND     = 400;
	localparam int          TOTAL_CYC  = RST_CYCLES + 4 + 5 * N_RAND + 6 * 2;
	localparam int          MARGIN_NS  = 400;
	localparam logic [31:0] SEED       = 32'hb47b9eb1;

	localparam int MODE_IDLE  = 0;
	localparam int MODE_ALU   = 1;
	localparam int MODE_FWD   = 2;
	localparam int MODE_BR    = 3;
	localparam int MODE_STALL = 4;
	localparam int MODE_LOAD  = 5;

	logic                  clk;
	logic                  rst;
	logic                  enb;
	logic                  kill;
	logic                  we_reg_file;
	logic [WB_SX_W-1:0]    wb_sx_op;
	logic [MUX_W-1:0]      mux_bus;
	logic [ALU_OP_W-1:0]   alu_op;
	logic [BR_W-1:0]       br_cnd;
	logic                  l1d_val;
	logic                  l1d_wr;
	logic [L1D_SIZE_W-1:0] l1d_size;
	logic [XLEN-1:0]       src1;
	logic [XLEN-1:0]       src2;
	logic [XLEN-1:0]       pc;
	logic [XLEN-1:0]       pc_4;
	logic [XLEN-1:0]       sx_imm;
	logic [REG_W-1:0]      rs1;
	logic [REG_W-1:0]      rs2;
	logic [REG_W-1:0]      rd;
	logic [XLEN-1:0]       wb_result;
	logic [REG_W-1:0]      wb_rd;
	logic                  wb_we;
	logic                  we_reg_file_q;
	logic [WB_SX_W-1:0]    wb_sx_op_q;
	logic                  l1d_val_q;
	logic                  l1d_wr_q;
	logic [L1D_SIZE_W-1:0] l1d_size_q;
	logic                  result_sel_mem_q;
	logic [XLEN-1:0]       alu_result_q;
	logic [XLEN-1:0]       w_data_q;
	logic [XLEN-1:0]       addr_q;
	logic [XLEN-1:0]       pc_4_q;
	logic [REG_W-1:0]      rd_q;
	logic                  branch_taken;
	logic [XLEN-1:0]       branch_target;
	logic                  load_use;
	int                    err_cnt;
	int                    chk_cnt;
	int                    test_cnt = 0;
	int                    tests_failed = 0;

	exe_top u_dut (.*);

	exe_checker u_chk (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// nop with the register advancing
	task automatic set_idle();
		enb         = 1'b1;
		kill        = 1'b0;
		we_reg_file = 1'b0;
		wb_sx_op    = '0;
		mux_bus     = '0;
		alu_op      = ALU_ADD;
		br_cnd      = BR_NONE;
		l1d_val     = 1'b0;
		l1d_wr      = 1'b0;
		l1d_size    = '0;
		src1        = '0;
		src2        = '0;
		pc          = '0;
		pc_4        = 32'd4;
		sx_imm      = '0;
		rs1         = '0;
		rs2         = '0;
		rd          = '0;
		wb_result   = '0;
		wb_rd       = '0;
		wb_we       = 1'b0;
	endtask

	task automatic drive_cycle(input int mode);
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] t;
		r = $urandom;
		s = $urandom;
		t = $urandom;
		set_idle();
		if (mode != MODE_IDLE) begin
			we_reg_file = (mode == MODE_ALU) ? 1'b0 : r[0];
			wb_sx_op    = r[3:1];
			mux_bus     = r[8:4];
			alu_op      = r[12:9];
			br_cnd      = r[15:13];
			l1d_val     = r[16] | (mode == MODE_LOAD);
			l1d_wr      = r[17] & r[18];
			l1d_size    = r[21:19];
			src1        = $urandom;
			// equal operands now and then for eq/ne/ge
			src2        = (r[23:22] == 2'b00) ? src1 : $urandom;
			pc          = $urandom & 32'hffff_fffc;
			pc_4        = pc + 32'd4;
			sx_imm      = r[24] ? $urandom : {{20{s[11]}}, s[11:0]};
			wb_we       = (mode == MODE_ALU) ? 1'b0 : r[25];
			wb_result   = $urandom;
			if (mode == MODE_FWD || mode == MODE_STALL || mode == MODE_LOAD) begin
				// x0..x3 so that indices collide often
				rs1   = {3'b0, s[13:12]};
				rs2   = {3'b0, s[15:14]};
				rd    = {3'b0, s[17:16]};
				wb_rd = {3'b0, s[19:18]};
			end else begin
				rs1   = t[4:0];
				rs2   = t[9:5];
				rd    = t[14:10];
				wb_rd = t[19:15];
			end
			if (mode == MODE_STALL) begin
				enb  = r[26];
				kill = (r[29:27] == 3'b000);
			end
		end
	endtask

	task automatic run_test(input string name, input int mode, input int cycles);
		int errs_before;
		errs_before = err_cnt;
		repeat (cycles) begin
			@(negedge clk);
			drive_cycle(mode);
		end
		// one more edge so the last result is compared
		@(negedge clk);
		set_idle();
		@(negedge clk);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %0d %s: pass", test_cnt, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d mismatches", test_cnt, name, err_cnt - errs_before);
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		void'($urandom(SEED));
		rst = 1'b1;
		set_idle();
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		run_test("reset", MODE_IDLE, 4);
		run_test("alu and operand select", MODE_ALU, N_RAND);
		run_test("forwarding priority", MODE_FWD, N_RAND);
		run_test("branches and addresses", MODE_BR, N_RAND);
		run_test("stall and kill", MODE_STALL, N_RAND);
		run_test("load-use", MODE_LOAD, N_RAND);
		$display("%0d tests, %0d failed, %0d checks, %0d mismatches",
			test_cnt, tests_failed, chk_cnt, err_cnt);
		if (err_cnt == 0 && tests_failed == 0 && chk_cnt > 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TOTAL_CYC * CLK_PERIOD + MARGIN_NS);
		$display("timeout: the tests did not finish in the expected time");
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
rtl/exe_pkg.sv
rtl/exe_alu.sv
rtl/exe_hazard.sv
rtl/exe_stage.sv
rtl/exe_top.sv
sim/exe_assert.sv
sim/exe_checker.sv
sim/exe_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exe_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
